// File: filelist.f
+incdir+logic
logic/conv_pkg.sv
logic/weight_store.sv
logic/line_window.sv
logic/kc_pe.sv
logic/psum_reduce.sv
logic/line_conv_top.sv
dv/line_conv_assert.sv
dv/line_conv_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module line_conv_tb -f filelist.f -o line_conv_sim
	./obj_dir/line_conv_sim +verilator+error+limit+1000 | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/line_conv_tb.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module line_conv_tb
    import conv_pkg::*;
();

    localparam int ROW_WIDTH   = 8;
    localparam int NUM_ROWS    = 4;
    localparam int NUM_PIX     = ROW_WIDTH * NUM_ROWS;
    localparam int NUM_RESULTS = NUM_ROWS * (ROW_WIDTH - 2);
    localparam int RST_CYCLES  = 10;
    // Reset, five weight strobes, pixels with gaps, pipeline drain
    localparam int TEST_CYCLES = RST_CYCLES + 6 + 2 * NUM_PIX + 4;
    localparam int MAX_CYCLES  = 4 * TEST_CYCLES;

    logic        clk;
    logic        rst;
    pos_weight_t i_weight;
    logic        i_weight_vld;
    logic        o_weight_req;
    pixel_t      i_data;
    logic        i_data_vld;
    logic        o_data_req;
    cnt_t        i_row_width;
    cnt_t        i_num_rows;
    conv_out_s   o_result;
    logic        o_done;

    logic [15:0] lfsr;
    pos_weight_t ref_w [`CONV_NUM_POS];
    pixel_t      row_buf [ROW_WIDTH];
    kn_psum_t    exp_q [$];
    logic        exp_end_q [$];
    int          cycles;
    int          value_errs;
    int          other_errs;
    int          results;
    int          rows_out;
    logic        done_exp;

    line_conv_top DUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
    end

    // 16-bit Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return bits;
    endfunction

    // Sum over positions and channels of signed pixel times weight
    task automatic push_expected(input int col);
        kn_psum_t want;
        int       acc;
        for (int k = 0; k < `CONV_NUM_KERNEL; k++) begin
            acc = 0;
            for (int p = 0; p < `CONV_NUM_POS; p++) begin
                for (int c = 0; c < `CONV_NUM_CHANNEL; c++) begin
                    acc += int'(row_buf[col - 2 + p][c]) * int'(ref_w[p][k][c]);
                end
            end
            want[k] = acc[`CONV_PSUM_WIDTH-1:0];
        end
        exp_q.push_back(want);
        exp_end_q.push_back(col == ROW_WIDTH - 1);
    endtask

    // Two strobes after loading must be ignored
    task automatic load_weights();
        for (int n = 0; n < `CONV_NUM_POS + 2; n++) begin
            @(posedge clk);
            #1;
            i_weight     = {rand_bits(32), rand_bits(32), rand_bits(32)};
            i_weight_vld = 1'b1;
            if (n < `CONV_NUM_POS) begin
                ref_w[n] = i_weight;
            end
        end
        @(posedge clk);
        #1;
        i_weight_vld = 1'b0;
    endtask

    task automatic send_pixels();
        logic [31:0] bits;
        int          col;
        int          sent;
        col  = 0;
        sent = 0;
        while (sent < NUM_PIX) begin
            @(posedge clk);
            #1;
            bits = rand_bits(2);
            i_data_vld = 1'b0;
            // Roughly one cycle in four is a gap
            if (bits[1:0] != 2'b00 && !o_data_req) begin
                other_errs++;
                $display("Data request low at %0t ns with pixels left to send", $time);
            end else if (bits[1:0] != 2'b00) begin
                bits         = rand_bits(24);
                i_data       = bits[23:0];
                i_data_vld   = 1'b1;
                row_buf[col] = i_data;
                if (col >= `CONV_NUM_POS - 1) begin
                    push_expected(col);
                end
                col = (col == ROW_WIDTH - 1) ? 0 : col + 1;
                sent++;
            end
        end
        @(posedge clk);
        #1;
        i_data_vld = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Result monitor, sampled mid-cycle
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            if (o_done !== done_exp) begin
                value_errs++;
                $display("[FAIL] %0t ns o_done expected %0b got %0b", $time, done_exp, o_done);
            end
            if (o_result.vld && exp_q.size() == 0) begin
                other_errs++;
                $display("Result at %0t ns with no window left to match", $time);
            end else if (o_result.vld) begin
                for (int k = 0; k < `CONV_NUM_KERNEL; k++) begin
                    if (o_result.psum[k] !== exp_q[0][k]) begin
                        value_errs++;
                        $display("[FAIL] %0t ns o_result.psum[%0d] expected %0d got %0d",
                                 $time, k, exp_q[0][k], o_result.psum[k]);
                    end
                end
                if (o_result.row_end !== exp_end_q[0]) begin
                    value_errs++;
                    $display("[FAIL] %0t ns o_result.row_end expected %0b got %0b",
                             $time, exp_end_q[0], o_result.row_end);
                end
                // Done is due one cycle after the final row end
                if (exp_end_q[0]) begin
                    rows_out++;
                    done_exp = (rows_out == NUM_ROWS);
                end
                results++;
                void'(exp_q.pop_front());
                void'(exp_end_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with done still low", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        i_weight     = '0;
        i_weight_vld = 1'b0;
        i_data       = '0;
        i_data_vld   = 1'b0;
        i_row_width  = cnt_t'(ROW_WIDTH);
        i_num_rows   = cnt_t'(NUM_ROWS);
        lfsr         = 16'd23785;
        cycles       = 0;
        value_errs   = 0;
        other_errs   = 0;
        results      = 0;
        rows_out     = 0;
        done_exp     = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        load_weights();
        send_pixels();
        while (!o_done) @(negedge clk);
        // Watch done hold for a few more cycles
        repeat (4) @(negedge clk);
        if (results != NUM_RESULTS || o_data_req) begin
            other_errs++;
            $display("Got %0d results instead of %0d, data request %0b after the last row",
                     results, NUM_RESULTS, o_data_req);
        end
        $display("Errors: %0d wrong values, %0d other, %0d assertion failures",
                 value_errs, other_errs, DUT.u_assert.fail_cnt);
        if (value_errs + other_errs + DUT.u_assert.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: dv/line_conv_assert.sv
`timescale 1ns/1ps

module line_conv_assert
    import conv_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      i_weight_vld,
    input logic      o_weight_req,
    input logic      o_data_req,
    input conv_out_s o_result,
    input logic      o_done
);

    int         fail_cnt = 0;
    logic [2:0] strobe_cnt;

    function automatic void count_failure(input string what);
        fail_cnt++;
        $error("Assertion failed: %s", what);
    endfunction

    // Weight strobes taken while the request is up
    always_ff @(posedge clk) begin
        if (rst) begin
            strobe_cnt <= '0;
        end else if (i_weight_vld && o_weight_req) begin
            strobe_cnt <= strobe_cnt + 3'd1;
        end
    end

    //////////////////////////////////////////////////
    // Reset and weight loading
    //////////////////////////////////////////////////

    assert property (@(posedge clk)
        rst |=> !o_result.vld && !o_done && !o_data_req && o_weight_req)
        else count_failure("outputs not at their reset values");

    assert property (@(posedge clk) disable iff (rst)
        o_weight_req == (strobe_cnt < 3'd3))
        else count_failure("weight request not dropped after exactly three strobes");

    assert property (@(posedge clk) disable iff (rst)
        o_weight_req |-> !o_data_req)
        else count_failure("data request raised before the weights were loaded");

    //////////////////////////////////////////////////
    // Result flags and done
    //////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        o_done |-> !o_result.vld)
        else count_failure("result still valid after done");

    assert property (@(posedge clk) disable iff (rst)
        o_done |-> !o_data_req)
        else count_failure("data request still high after done");

endmodule

bind line_conv_top line_conv_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .i_weight_vld (i_weight_vld),
    .o_weight_req (o_weight_req),
    .o_data_req   (o_data_req),
    .o_result     (o_result),
    .o_done       (o_done)
);

// File: logic/line_conv_top.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module line_conv_top import conv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  pos_weight_t i_weight,
    input  logic        i_weight_vld,
    output logic        o_weight_req,
    input  pixel_t      i_data,
    input  logic        i_data_vld,
    output logic        o_data_req,
    input  cnt_t        i_row_width,
    input  cnt_t        i_num_rows,
    output conv_out_s   o_result,
    output logic        o_done
);

    pos_weight_t weights [`CONV_NUM_POS];
    logic        loaded;
    window_s     window;
    pe_out_s     pe_out [`CONV_NUM_POS];

    weight_store u_weight_store (
        .clk          (clk),
        .rst          (rst),
        .i_weight     (i_weight),
        .i_weight_vld (i_weight_vld),
        .o_weights    (weights),
        .o_loaded     (loaded),
        .o_weight_req (o_weight_req)
    );

    line_window u_line_window (
        .clk         (clk),
        .rst         (rst),
        .i_data      (i_data),
        .i_data_vld  (i_data_vld),
        .i_loaded    (loaded),
        .i_row_width (i_row_width),
        .i_num_rows  (i_num_rows),
        .o_data_req  (o_data_req),
        .o_window    (window)
    );

    // One PE per kernel position
    for (genvar p = 0; p < `CONV_NUM_POS; p++) begin : g_pe
        kc_pe u_pe (
            .clk          (clk),
            .rst          (rst),
            .i_window_pix (window.pix[p]),
            .i_weight     (weights[p]),
            .i_vld        (window.vld),
            .i_row_end    (window.row_end),
            .o_pe         (pe_out[p])
        );
    end

    psum_reduce u_psum_reduce (
        .clk        (clk),
        .rst        (rst),
        .i_pe       (pe_out),
        .i_num_rows (i_num_rows),
        .o_result   (o_result),
        .o_done     (o_done)
    );

endmodule

// File: logic/psum_reduce.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module psum_reduce import conv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  pe_out_s   i_pe [`CONV_NUM_POS],
    input  cnt_t      i_num_rows,
    output conv_out_s o_result,
    output logic      o_done
);

    kn_psum_t sum;
    kn_psum_t res_psum_q;
    logic     res_vld_q;
    logic     res_end_q;
    cnt_t     rows_q;
    logic     done_q;

    //////////////////////////////////////////////////
    // Position reduction
    //////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < `CONV_NUM_KERNEL; k++) begin
            sum[k] = '0;
            for (int p = 0; p < `CONV_NUM_POS; p++) begin
                sum[k] = sum[k] + i_pe[p].psum[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_pe[0].vld) begin
            res_psum_q <= sum;
        end
    end

    // All PEs run in lockstep, position 0 carries the flags
    always_ff @(posedge clk) begin
        if (rst) begin
            res_vld_q <= 1'b0;
            res_end_q <= 1'b0;
        end else begin
            res_vld_q <= i_pe[0].vld;
            res_end_q <= i_pe[0].vld & i_pe[0].row_end;
        end
    end

    //////////////////////////////////////////////////
    // Finished rows
    //////////////////////////////////////////////////

    // Done follows the final row-end result by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rows_q <= '0;
            done_q <= 1'b0;
        end else if (res_vld_q & res_end_q) begin
            rows_q <= rows_q + cnt_t'(1);
            if (rows_q == i_num_rows - cnt_t'(1)) begin
                done_q <= 1'b1;
            end
        end
    end

    assign o_result = '{psum: res_psum_q, vld: res_vld_q, row_end: res_end_q};
    assign o_done   = done_q;

endmodule

// File: logic/kc_pe.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module kc_pe import conv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  pixel_t      i_window_pix,
    input  pos_weight_t i_weight,
    input  logic        i_vld,
    input  logic        i_row_end,
    output pe_out_s     o_pe
);

    kn_psum_t dot;
    kn_psum_t psum_q;
    logic     vld_q;
    logic     row_end_q;

    // Channel dot product per kernel, signed throughout
    always_comb begin
        for (int k = 0; k < `CONV_NUM_KERNEL; k++) begin
            dot[k] = '0;
            for (int c = 0; c < `CONV_NUM_CHANNEL; c++) begin
                dot[k] = dot[k] + i_window_pix[c] * i_weight[k][c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_vld) begin
            psum_q <= dot;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q     <= 1'b0;
            row_end_q <= 1'b0;
        end else begin
            vld_q     <= i_vld;
            row_end_q <= i_vld & i_row_end;
        end
    end

    assign o_pe = '{psum: psum_q, vld: vld_q, row_end: row_end_q};

endmodule

// File: logic/line_window.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module line_window import conv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  pixel_t  i_data,
    input  logic    i_data_vld,
    input  logic    i_loaded,
    input  cnt_t    i_row_width,
    input  cnt_t    i_num_rows,
    output logic    o_data_req,
    output window_s o_window
);

    pixel_t [`CONV_NUM_POS-1:0] taps_q;
    logic                       vld_q;
    logic                       row_end_q;

    cnt_t col_q;
    cnt_t row_q;
    logic rows_done_q;
    logic accept;
    logic col_last;
    logic row_last;

    //////////////////////////////////////////////////
    // Intake and position counters
    //////////////////////////////////////////////////

    assign o_data_req = i_loaded & ~rows_done_q;
    assign accept     = i_data_vld & o_data_req;
    assign col_last   = (col_q == i_row_width - cnt_t'(1));
    assign row_last   = (row_q == i_num_rows - cnt_t'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            col_q       <= '0;
            row_q       <= '0;
            rows_done_q <= 1'b0;
        end else if (accept) begin
            col_q <= col_last ? '0 : col_q + cnt_t'(1);
            if (col_last) begin
                row_q <= row_q + cnt_t'(1);
                // Intake closes with the last pixel of the last row
                if (row_last) begin
                    rows_done_q <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Three-position window
    //////////////////////////////////////////////////

    // Newest pixel enters at the top position
    always_ff @(posedge clk) begin
        if (accept) begin
            taps_q <= {i_data, taps_q[`CONV_NUM_POS-1:1]};
        end
    end

    // Full window only from the third pixel of a row on
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q     <= 1'b0;
            row_end_q <= 1'b0;
        end else begin
            vld_q     <= accept & (col_q >= cnt_t'(`CONV_NUM_POS - 1));
            row_end_q <= accept & col_last;
        end
    end

    assign o_window = '{pix: taps_q, vld: vld_q, row_end: row_end_q};

endmodule

// File: logic/weight_store.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module weight_store import conv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  pos_weight_t i_weight,
    input  logic        i_weight_vld,
    output pos_weight_t o_weights [`CONV_NUM_POS],
    output logic        o_loaded,
    output logic        o_weight_req
);

    logic [1:0] slot_q;
    logic       loaded_q;
    logic       take;

    // Strobes after the third word are dropped
    assign take = i_weight_vld & ~loaded_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_q   <= '0;
            loaded_q <= 1'b0;
        end else if (take) begin
            slot_q <= slot_q + 2'd1;
            if (slot_q == 2'(`CONV_NUM_POS - 1)) begin
                loaded_q <= 1'b1;
            end
        end
    end

    // Word k feeds the PE of position k
    always_ff @(posedge clk) begin
        if (take) begin
            o_weights[slot_q] <= i_weight;
        end
    end

    assign o_loaded     = loaded_q;
    assign o_weight_req = ~loaded_q;

endmodule

// File: logic/conv_pkg.sv
package conv_pkg;

`include "conv_settings.svh"

    //////////////////////////////////////////////////
    // Scalar and vector types
    //////////////////////////////////////////////////

    typedef logic signed [`CONV_BIT_WIDTH-1:0] pix_t;

    // One pixel, channel 0 in the low bits
    typedef pix_t [`CONV_NUM_CHANNEL-1:0] pixel_t;

    // One kernel at one position, all channels
    typedef pix_t [`CONV_NUM_CHANNEL-1:0] kweight_t;

    // One weight word, kernel 0 in the low bits
    typedef kweight_t [`CONV_NUM_KERNEL-1:0] pos_weight_t;

    typedef logic signed [`CONV_PSUM_WIDTH-1:0] psum_t;
    typedef psum_t [`CONV_NUM_KERNEL-1:0] kn_psum_t;

    typedef logic [`CONV_CNT_WIDTH-1:0] cnt_t;

    //////////////////////////////////////////////////
    // Pipeline structs
    //////////////////////////////////////////////////

    // Position 0 holds the oldest pixel
    typedef struct packed {
        pixel_t [`CONV_NUM_POS-1:0] pix;
        logic                       vld;
        logic                       row_end;
    } window_s;

    typedef struct packed {
        kn_psum_t psum;
        logic     vld;
        logic     row_end;
    } pe_out_s;

    // Final result, same layout as a PE result
    typedef pe_out_s conv_out_s;

endpackage

// File: logic/conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Pixel and weight width
`define CONV_BIT_WIDTH   8
// Wide enough for 9 signed 8x8 products
`define CONV_PSUM_WIDTH  20

//////////////////////////////////////////////////
// Array dimensions
//////////////////////////////////////////////////

`define CONV_NUM_CHANNEL 3
`define CONV_NUM_KERNEL  4
// Kernel width, one PE per position
`define CONV_NUM_POS     3

// Row width and row count configuration
`define CONV_CNT_WIDTH   8

`endif
